// ==== dw_pkg.sv ====
`default_nettype none

package dw_pkg;

  // Accumulator stream geometry.
  localparam int WORD_WIDTH = 16;
  localparam int UNITS      = 2;
  localparam int MEMBERS    = 12;
  localparam int LANES      = 2;

  // Stage-B depth in columns.
  localparam int B_COLS = 4;

  localparam int CLR_WIDTH    = 2;
  localparam int BITS_SHIFT_A = 4;
  localparam int BITS_SHIFT_B = 2;
  localparam int TAG_WIDTH    = 8;

  typedef logic [UNITS-1:0][WORD_WIDTH-1:0] dw_col_t;

  typedef dw_col_t [MEMBERS-1:0] dw_window_t;

  // Kernel width is 2*kw2+1, stride is sw_1+1.
  typedef struct packed {
    logic                 kw2;
    logic                 sw_1;
    logic [TAG_WIDTH-1:0] tag;
  } dw_base_t;

  typedef struct packed {
    logic [MEMBERS-1:0][CLR_WIDTH-1:0] clr;
    logic [BITS_SHIFT_B-1:0]           shift_b;
    logic [BITS_SHIFT_A-1:0]           shift_a;
    dw_base_t                          base;
  } dw_in_user_t;

  typedef struct packed {
    logic [CLR_WIDTH-1:0] clr;
    dw_base_t             base;
  } dw_out_user_t;

  typedef struct packed {
    dw_window_t [LANES-1:0] window;
    dw_in_user_t            user;
    logic                   last;
  } dw_in_beat_t;

  typedef struct packed {
    dw_window_t  window;
    dw_in_user_t user;
    logic        last;
  } dw_lane_beat_t;

  typedef struct packed {
    dw_col_t      col;
    dw_out_user_t user;
    logic         last;
  } dw_lane_out_t;

  typedef struct packed {
    dw_col_t [LANES-1:0] col;
    dw_out_user_t        user;
    logic                last;
  } dw_out_beat_t;

  // A column kept together with its clear tag inside a lane.
  typedef struct packed {
    dw_col_t              col;
    logic [CLR_WIDTH-1:0] clr;
  } dw_slot_t;

endpackage

`default_nettype wire

// ==== dw_bank_dispatch.sv ====
`default_nettype none

module dw_bank_dispatch (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  input  dw_pkg::dw_in_beat_t       s_beat,
  output logic                      s_ready,
  output logic                      lane_valid,
  output dw_pkg::dw_lane_beat_t     lane_beat [dw_pkg::LANES],
  input  logic [dw_pkg::LANES-1:0]  lane_ready
);
  import dw_pkg::*;

  logic        run;
  logic        d_valid;
  logic        d_take;
  dw_in_beat_t d_beat;

  // The lanes take the beat together, so all of them must be ready.
  assign d_take  = d_valid & (&lane_ready);
  assign s_ready = run & (~d_valid | d_take);

  // Holds s_ready low until the first cycle after reset.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      d_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (s_valid && s_ready) begin
        d_valid <= 1'b1;
      end else if (d_take) begin
        d_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      d_beat <= s_beat;
    end
  end

  assign lane_valid = d_valid;

  // Every lane gets its own window and the shared sideband.
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_beat[i].window = d_beat.window[i];
      lane_beat[i].user   = d_beat.user;
      lane_beat[i].last   = d_beat.last;
    end
  end

endmodule

`default_nettype wire

// ==== dw_shift_lane.sv ====
`default_nettype none

module dw_shift_lane (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  dw_pkg::dw_lane_beat_t in_beat,
  output logic                  in_ready,
  output logic                  out_valid,
  output dw_pkg::dw_lane_out_t  out_beat,
  input  logic                  out_take
);
  import dw_pkg::*;

  // Stage A holds the window and steps it toward the high index.
  logic                    a_valid;
  logic [BITS_SHIFT_A-1:0] a_cnt;
  logic                    a_cnt_zero;
  logic                    a_load;
  logic                    a_step;
  logic                    a_last;
  logic [BITS_SHIFT_B-1:0] a_shift_b;
  dw_base_t                a_base;
  dw_slot_t [MEMBERS-1:0]  a_win;
  dw_slot_t [MEMBERS-1:0]  a_win_in;

  // Stage B holds the selected columns and emits them one by one.
  logic                    b_valid;
  logic [BITS_SHIFT_B-1:0] b_cnt;
  logic                    b_cnt_zero;
  logic                    b_ready;
  logic                    b_load;
  logic                    b_step;
  logic                    b_last;
  dw_base_t                b_base;
  dw_slot_t [B_COLS-1:0]   b_slots;
  dw_slot_t [B_COLS-1:0]   b_sel;

  // Column distance j = kernel width + stride - 1, from 1 to 4.
  logic [2:0]              col_step;

  assign a_cnt_zero = (a_cnt == '0);
  assign b_cnt_zero = (b_cnt == '0);

  // Stage B is free when empty or when it emits its final column now.
  assign b_ready = ~b_valid | (b_cnt_zero & out_take);
  assign b_load  = a_valid & b_ready;
  assign b_step  = b_valid & out_take & ~b_cnt_zero;

  // A new beat enters only once the previous one has made its last step.
  assign in_ready = a_cnt_zero & b_ready;
  assign a_load   = in_valid & in_ready;
  assign a_step   = b_load & ~a_cnt_zero;

  // Pair every column with its clear tag.
  always_comb begin
    for (int m = 0; m < MEMBERS; m++) begin
      a_win_in[m].col = in_beat.window[m];
      a_win_in[m].clr = in_beat.user.clr[m];
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      a_valid <= 1'b0;
      a_cnt   <= '0;
    end else begin
      if (a_load) begin
        a_valid <= 1'b1;
        a_cnt   <= in_beat.user.shift_a;
      end else if (b_load && a_cnt_zero) begin
        a_valid <= 1'b0;
      end else if (a_step) begin
        a_cnt <= a_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (a_load) begin
      a_win     <= a_win_in;
      a_shift_b <= in_beat.user.shift_b;
      a_base    <= in_beat.user.base;
      a_last    <= in_beat.last;
    end else if (a_step) begin
      // Zero column and zero tag come in at index 0.
      a_win <= {a_win[MEMBERS-2:0], dw_slot_t'('0)};
    end
  end

  // Slot n takes view column n*j+j-1; past the window it stays zero.
  always_comb begin
    col_step = {1'b0, a_base.kw2, 1'b1} + {2'b00, a_base.sw_1};
    b_sel    = '0;
    for (int n = 0; n < B_COLS; n++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (m == (n + 1) * col_step - 1) begin
          b_sel[n] = a_win[m];
        end
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
      b_cnt   <= '0;
    end else begin
      if (b_load) begin
        b_valid <= 1'b1;
        b_cnt   <= a_shift_b;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end else if (b_step) begin
        b_cnt <= b_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (b_load) begin
      b_slots <= b_sel;
      b_base  <= a_base;
      // Only the final view of a last beat may end the packet.
      b_last  <= a_last & a_cnt_zero;
    end else if (b_step) begin
      b_slots <= {dw_slot_t'('0), b_slots[B_COLS-1:1]};
    end
  end

  assign out_valid          = b_valid;
  assign out_beat.col       = b_slots[0].col;
  assign out_beat.user.clr  = b_slots[0].clr;
  assign out_beat.user.base = b_base;
  assign out_beat.last      = b_last & b_cnt_zero;

endmodule

`default_nettype wire

// ==== dw_bank_merge.sv ====
`default_nettype none

module dw_bank_merge (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic [dw_pkg::LANES-1:0] out_valid,
  input  dw_pkg::dw_lane_out_t     out_beat [dw_pkg::LANES],
  output logic                     out_take,
  input  logic                     m_ready,
  output logic                     m_valid,
  output dw_pkg::dw_out_beat_t     m_beat
);
  import dw_pkg::*;

  logic                m_last;
  logic                can_load;
  dw_col_t [LANES-1:0] m_col;
  dw_col_t [LANES-1:0] join_col;
  dw_out_user_t        m_user;

  // Output register is empty or drains this cycle.
  assign can_load = ~m_valid | m_ready;

  // One take for all lanes keeps them in lockstep.
  assign out_take = (&out_valid) & can_load;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      join_col[i] = out_beat[i].col;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else begin
      if (out_take) begin
        m_valid <= 1'b1;
        m_last  <= out_beat[0].last;
      end else if (m_ready) begin
        m_valid <= 1'b0;
        m_last  <= 1'b0;
      end
    end
  end

  // Sideband comes from lane 0 since all lanes carry the same one.
  always_ff @(posedge aclk) begin
    if (out_take) begin
      m_col  <= join_col;
      m_user <= out_beat[0].user;
    end
  end

  assign m_beat.col  = m_col;
  assign m_beat.user = m_user;
  assign m_beat.last = m_last;

endmodule

`default_nettype wire

// ==== dw_bank_top.sv ====
`default_nettype none

module dw_bank_top (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  input  dw_pkg::dw_in_beat_t  s_beat,
  output logic                 s_ready,
  input  logic                 m_ready,
  output logic                 m_valid,
  output dw_pkg::dw_out_beat_t m_beat
);
  import dw_pkg::*;

  logic               lane_valid;
  logic [LANES-1:0]   lane_ready;
  dw_lane_beat_t      lane_beat [LANES];
  logic [LANES-1:0]   out_valid;
  dw_lane_out_t       out_beat [LANES];
  logic               out_take;

  dw_bank_dispatch u_dispatch (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_beat     (s_beat),
    .s_ready    (s_ready),
    .lane_valid (lane_valid),
    .lane_beat  (lane_beat),
    .lane_ready (lane_ready)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    dw_shift_lane u_lane (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (lane_valid),
      .in_beat   (lane_beat[i]),
      .in_ready  (lane_ready[i]),
      .out_valid (out_valid[i]),
      .out_beat  (out_beat[i]),
      .out_take  (out_take)
    );
  end

  dw_bank_merge u_merge (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_take  (out_take),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_beat    (m_beat)
  );

endmodule

`default_nettype wire

// ==== dw_bank_checker.sv ====
`default_nettype none

module dw_bank_checker (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  logic                 s_ready,
  input  logic                 m_valid,
  input  logic                 m_ready,
  input  dw_pkg::dw_out_beat_t m_beat,
  output int                   error_count,
  output int                   check_count,
  output int                   rows_done,
  output int                   pending
);
  timeunit 1ns;
  timeprecision 1ps;
  import dw_pkg::*;

  dw_out_beat_t exp_q [$];
  dw_out_beat_t exp_beat;
  int           row_outputs;
  int           row_errors;
  int           since_reset;

  initial begin
    error_count = 0;
    check_count = 0;
    rows_done   = 0;
    pending     = 0;
    row_outputs = 0;
    row_errors  = 0;
    since_reset = 0;
  end

  // Expands one accepted input beat into its output columns.
  task automatic expect_beat(input dw_in_beat_t beat);
    int           j;
    int           v;
    int           c;
    dw_out_beat_t e;
    j = 2 * beat.user.base.kw2 + 1 + beat.user.base.sw_1;
    for (int i = 0; i <= beat.user.shift_a; i++) begin
      for (int t = 0; t <= beat.user.shift_b; t++) begin
        v = t * j + j - 1;
        c = v - i;
        e = '0;
        // A view column past the window reads zero even if its source exists.
        if (v < MEMBERS && c >= 0) begin
          for (int l = 0; l < LANES; l++) begin
            e.col[l] = beat.window[l][c];
          end
          e.user.clr = beat.user.clr[c];
        end
        e.user.base = beat.user.base;
        e.last = beat.last && (i == beat.user.shift_a) && (t == beat.user.shift_b);
        exp_q.push_back(e);
        pending++;
      end
    end
  endtask

  task automatic count_error();
    error_count++;
    row_errors++;
  endtask

  always @(negedge aclk) begin
    if (!rst_n) begin
      since_reset = 0;
      if (m_valid || m_beat.last || s_ready) begin
        $display("MISMATCH at %0t: valid, last or s_ready high during reset", $realtime);
        count_error();
      end
    end else begin
      if (since_reset < 2) begin
        since_reset++;
        if (m_valid || m_beat.last) begin
          $display("MISMATCH at %0t: m_valid or m_last high right after reset", $realtime);
          count_error();
        end
      end
      if (m_valid && m_ready) begin
        check_count++;
        row_outputs++;
        if (exp_q.size() == 0) begin
          $display("Output beat at %0t arrived when no output was expected", $realtime);
          count_error();
        end else begin
          exp_beat = exp_q.pop_front();
          pending--;
          if (m_beat !== exp_beat) begin
            $display("MISMATCH at %0t: row %0d output %0d expected %h got %h",
                     $realtime, rows_done, row_outputs - 1, exp_beat, m_beat);
            count_error();
          end
          if (exp_beat.last) begin
            $display("Row %0d finished: %0d outputs, %0d errors",
                     rows_done, row_outputs, row_errors);
            rows_done++;
            row_outputs = 0;
            row_errors  = 0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_dw_bank.sv ====
`default_nettype none

module tb_dw_bank;
  timeunit 1ns;
  timeprecision 1ps;
  import dw_pkg::*;

  localparam int NUM_ROWS = 9;

  typedef struct packed {
    logic                              kw2;
    logic                              sw_1;
    logic [BITS_SHIFT_A-1:0]           shift_a;
    logic [BITS_SHIFT_B-1:0]           shift_b;
    logic [3:0]                        beats;
    logic [MEMBERS*CLR_WIDTH-1:0]      clr;
    logic                              stall;
  } test_row_t;

  logic         aclk;
  logic         rst_n;
  logic         s_valid;
  logic         s_ready;
  logic         m_ready;
  logic         m_valid;
  dw_in_beat_t  s_beat;
  dw_out_beat_t m_beat;
  logic [31:0]  lfsr;
  int           error_count;
  int           check_count;
  int           rows_done;
  int           pending;
  int           cycles;
  int           limit;

  // kw2, sw_1, shift_a, shift_b, beats, clear tags, stall.
  test_row_t rows [NUM_ROWS] = '{
    '{1'b0, 1'b0, 4'd0,  2'd3, 4'd3, 24'h1be472, 1'b0},
    '{1'b0, 1'b1, 4'd0,  2'd3, 4'd2, 24'hc6a93f, 1'b0},
    '{1'b1, 1'b0, 4'd0,  2'd3, 4'd2, 24'h5d02b7, 1'b0},
    '{1'b1, 1'b1, 4'd0,  2'd3, 4'd2, 24'he3719c, 1'b0},
    '{1'b0, 1'b0, 4'd2,  2'd2, 4'd2, 24'h9a4e61, 1'b0},
    '{1'b1, 1'b1, 4'd5,  2'd3, 4'd2, 24'h27fd08, 1'b0},
    '{1'b0, 1'b1, 4'd3,  2'd1, 4'd4, 24'hb438e5, 1'b1},
    '{1'b1, 1'b0, 4'd15, 2'd3, 4'd2, 24'h6c1fa2, 1'b1},
    '{1'b0, 1'b0, 4'd1,  2'd0, 4'd6, 24'hf0935d, 1'b1}
  };

  dw_bank_top u_dw_bank_top (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_beat  (s_beat),
    .s_ready (s_ready),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat)
  );

  dw_bank_checker u_checker (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .s_ready     (s_ready),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_beat      (m_beat),
    .error_count (error_count),
    .check_count (check_count),
    .rows_done   (rows_done),
    .pending     (pending)
  );

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic make_beat(input int r, input int idx, output dw_in_beat_t beat);
    logic [31:0] w;
    beat = '0;
    for (int l = 0; l < LANES; l++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          draw_bits(WORD_WIDTH, w);
          beat.window[l][m][u] = w[WORD_WIDTH-1:0];
        end
      end
    end
    beat.user.clr       = rows[r].clr;
    beat.user.shift_a   = rows[r].shift_a;
    beat.user.shift_b   = rows[r].shift_b;
    beat.user.base.kw2  = rows[r].kw2;
    beat.user.base.sw_1 = rows[r].sw_1;
    beat.user.base.tag  = 8'(r * 16 + idx);
    beat.last           = (idx == rows[r].beats - 1);
  endtask

  // Feeds one row and keeps stepping until its last output has been checked.
  task automatic run_row(input int r);
    int          idx;
    logic        take;
    logic [31:0] bit_val;
    dw_in_beat_t beat;
    idx = 0;
    make_beat(r, 0, beat);
    while (rows_done <= r) begin
      s_valid = (idx < rows[r].beats);
      s_beat  = beat;
      if (rows[r].stall) begin
        draw_bits(1, bit_val);
        m_ready = bit_val[0];
      end else begin
        m_ready = 1'b1;
      end
      @(negedge aclk);
      take = s_valid && s_ready;
      @(posedge aclk);
      #1;
      if (take) begin
        u_checker.expect_beat(beat);
        idx++;
        if (idx < rows[r].beats) begin
          make_beat(r, idx, beat);
        end
      end
    end
    s_valid = 1'b0;
  endtask

  function automatic int timeout_limit();
    int sum;
    sum = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      sum += rows[r].beats * (rows[r].shift_a + 1) * (rows[r].shift_b + 1) * 4;
    end
    return sum;
  endfunction

  initial begin
    $timeformat(-9, 3, " ns", 10);
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;
    lfsr    = 32'hfbce;
    repeat (16) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    // Extra cycles so that any stray output is still caught.
    m_ready = 1'b1;
    repeat (8) @(posedge aclk);
    if (pending != 0) begin
      $display("%0d expected outputs never came out of the DUT", pending);
    end
    $display("Checks %0d, errors %0d, rows finished %0d of %0d",
             check_count, error_count, rows_done, NUM_ROWS);
    if (error_count == 0 && pending == 0 && rows_done == NUM_ROWS) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    limit  = timeout_limit();
    while (cycles < limit) begin
      @(posedge aclk);
      cycles++;
    end
    $display("Run timed out after %0d cycles with %0d rows finished", cycles, rows_done);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
dw_pkg.sv
dw_bank_dispatch.sv
dw_shift_lane.sv
dw_bank_merge.sv
dw_bank_top.sv
dw_bank_checker.sv
tb_dw_bank.sv
